// File: Makefile
TOP = tb_duckHunt
OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir $(OBJ)
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ)

// File: project.f
+incdir+verilog
verilog/gamePkg.sv
verilog/gameIfs.sv
verilog/gameSequencer.sv
verilog/duckFlight.sv
verilog/roundScore.sv
verilog/duckHuntTop.sv
tests/duckHuntChecker.sv
tests/tb_duckHunt.sv

// File: tests/duckHuntChecker.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module duckHuntChecker (
	input logic ANIM_Clk,
	input logic Reset,
	input logic run,
	input logic startGame,
	input logic duckKill,
	input logic [1:0] shotCount,
	input logic [1:0] colorRand,
	input logic [2:0] dirRand,
	input logic [1:0] repeatsRand,
	input logic [9:0] startXRand,
	input gamePkg::gameState state,
	input gamePkg::coord_t duckX,
	input gamePkg::coord_t duckY,
	input gamePkg::duckDir duckDir,
	input logic [1:0] duckColor,
	input logic flyAway,
	input logic shootEnable,
	input logic outOfShots,
	input logic gameOver,
	input logic [3:0] duckNumber,
	input logic [9:0] killMask,
	input logic [3:0] killTotal,
	input logic [7:0] roundNumber,
	output int errors,
	output int checks,
	output logic [4:0] seen
);

	gamePkg::gameState ms;	// Expected state
	gamePkg::gameState ns;
	gamePkg::duckDir md;
	int hold;
	int mx;
	int my;
	int mcol;
	int air;
	int tick;
	int leg;
	int legLen;
	int dn;
	int tot;
	int rnd;
	logic [9:0] mask;
	logic oos;
	logic go;

	initial
	begin
		errors = 0;
		checks = 0;
		seen = '0;
	end

	//////////////////////////////////////////////////////////////
	// Reference tables
	//////////////////////////////////////////////////////////////
	function automatic gamePkg::duckDir headingOf(input int code);
		if (code > 5)
			return gamePkg::SE;	// 6 and 7 fold onto SE
		return gamePkg::duckDir'(code);
	endfunction

	// Level headings move far in X, the rest far in Y
	function automatic int stepX(input gamePkg::duckDir d);
		int size;
		size = (d == gamePkg::W || d == gamePkg::E) ? `STEP_LG_X : `STEP_SM_X;
		return (d == gamePkg::NW || d == gamePkg::W || d == gamePkg::SW) ? -size : size;
	endfunction

	function automatic int stepY(input gamePkg::duckDir d);
		int size;
		size = (d == gamePkg::W || d == gamePkg::E) ? `STEP_SM_Y : `STEP_LG_Y;
		return (d == gamePkg::SW || d == gamePkg::SE) ? size : -size;
	endfunction

	function automatic gamePkg::duckDir mirrorSide(input gamePkg::duckDir d, input logic left);
		case (d)
			gamePkg::NW: return left ? gamePkg::NE : d;
			gamePkg::W: return left ? gamePkg::E : d;
			gamePkg::SW: return left ? gamePkg::SE : d;
			gamePkg::NE: return left ? d : gamePkg::NW;
			gamePkg::E: return left ? d : gamePkg::W;
			default: return left ? d : gamePkg::SW;
		endcase
	endfunction

	function automatic gamePkg::duckDir mirrorFloor(input gamePkg::duckDir d, input logic top);
		if (top)
			return (d == gamePkg::NW || d == gamePkg::W) ? gamePkg::SW :
				(d == gamePkg::NE || d == gamePkg::E) ? gamePkg::SE : d;
		return (d == gamePkg::SW) ? gamePkg::NW : (d == gamePkg::SE) ? gamePkg::NE : d;
	endfunction

	function automatic int holdLength(input gamePkg::gameState s);
		case (s)
			gamePkg::Intro: return `INTRO_TICKS;
			gamePkg::DuckHit: return `SHOCK_TICKS;
			gamePkg::DogShow: return `DOG_TICKS;
			gamePkg::FlyOff: return `FLYOFF_TICKS;
			gamePkg::DogLaugh: return `LAUGH_TICKS;
			gamePkg::GameOver: return `GAMEOVER_TICKS;
			gamePkg::NewRound: return `NEWROUND_TICKS;
			default: return 1;
		endcase
	endfunction

	function automatic int threshold(input int r);
		return (r <= 10) ? `THRESH_R10 : (r <= 12) ? `THRESH_R12 : (r <= 14) ? `THRESH_R14 :
			(r <= 19) ? `THRESH_R19 : `THRESH_HIGH;
	endfunction

	//////////////////////////////////////////////////////////////
	// Model and comparison
	//////////////////////////////////////////////////////////////
	task automatic compare(input string what, input int got, input int expected);
		checks++;
		if (got != expected)
		begin
			errors++;
			$display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic clearTally();
		dn = 0;
		mask = '0;
		tot = 0;
	endtask

	task automatic resetModel();
		ms = gamePkg::Idle;
		hold = 0;
		oos = 1'b0;
		mx = 400;
		my = 300;
		md = gamePkg::NW;
		mcol = 0;
		air = 0;
		tick = 0;
		leg = 0;
		legLen = 3;
		clearTally();
		rnd = 1;
		go = 1'b0;
	endtask

	task automatic compareAll();
		compare("state", int'(state), int'(ms));
		compare("duckX", int'(duckX), mx);
		compare("duckY", int'(duckY), my);
		compare("duckDir", int'(duckDir), int'(md));
		compare("duckColor", int'(duckColor), mcol);
		compare("flyAway", int'(flyAway), int'(air >= `FLYAWAY_WARN && air < `FLYAWAY_LIMIT));
		compare("shootEnable", int'(shootEnable), int'(ms == gamePkg::Fly));
		compare("outOfShots", int'(outOfShots), int'(oos));
		compare("gameOver", int'(gameOver), int'(go));
		compare("duckNumber", int'(duckNumber), dn);
		compare("killMask", int'(killMask), int'(mask));
		compare("killTotal", int'(killTotal), tot);
		compare("roundNumber", int'(roundNumber), rnd);
	endtask

	task automatic advanceModel();
		logic holdDone;
		logic atEdge;
		logic rdone;
		holdDone = (hold == holdLength(ms) - 1);
		atEdge = (mx <= 0 || mx >= `FIELD_X_MAX || my <= `FIELD_Y_MIN || my >= `FIELD_Y_START);
		rdone = (dn >= `DUCKS_PER_ROUND);
		seen = seen | {ms == gamePkg::GameOver, ms == gamePkg::DogLaugh && oos,
			ms == gamePkg::FlyOff, ms == gamePkg::DuckHit, ms == gamePkg::Bounce};

		ns = ms;
		case (ms)
			gamePkg::Idle: if (run) ns = gamePkg::MainMenu;
			gamePkg::MainMenu: if (startGame) ns = gamePkg::Intro;
			gamePkg::Intro: if (holdDone) ns = gamePkg::DuckStart;
			gamePkg::DuckStart, gamePkg::Bounce: ns = gamePkg::Fly;
			gamePkg::Fly:
			begin
				if (oos)
					ns = gamePkg::DogLaugh;
				else if (air >= `FLYAWAY_LIMIT)
					ns = gamePkg::FlyOff;
				else if (duckKill)
					ns = gamePkg::DuckHit;
				else if (atEdge)
					ns = gamePkg::Bounce;
			end
			gamePkg::DuckHit: if (holdDone) ns = gamePkg::DuckFall;
			gamePkg::DuckFall: if (my > `FALL_Y_END) ns = gamePkg::DogShow;
			gamePkg::DogShow, gamePkg::DogLaugh:
				if (holdDone)
					ns = rdone ? gamePkg::EndRound : gamePkg::DuckStart;
			gamePkg::FlyOff: if (holdDone) ns = gamePkg::DogLaugh;
			gamePkg::EndRound: ns = go ? gamePkg::GameOver : gamePkg::NewRound;
			gamePkg::GameOver: if (holdDone) ns = gamePkg::MainMenu;
			default: if (holdDone) ns = gamePkg::Intro;
		endcase

		// Score strobes come from the first tick of a state
		if (ms == gamePkg::MainMenu && hold == 0)
		begin
			clearTally();
			rnd = 1;
			go = 1'b0;
		end
		else
		begin
			if (rdone)
				go = (tot < threshold(rnd));
			if (ms == gamePkg::NewRound && hold == 0)
			begin
				rnd++;
				clearTally();
			end
			else if (ms == gamePkg::DuckStart)
				dn++;
			else if (ms == gamePkg::DuckHit && hold == 0)
			begin
				mask[dn - 1] = 1'b1;
				tot++;
			end
		end

		if (ms == gamePkg::DuckStart)
			oos = 1'b0;
		else if (ms == gamePkg::Fly && shotCount == 2'd3)
			oos = 1'b1;

		case (ms)
			gamePkg::DuckStart:
			begin
				mx = int'(startXRand);
				my = `FIELD_Y_START;
				md = headingOf(int'(dirRand));
				mcol = (colorRand == 2'd3) ? 0 : int'(colorRand);
				air = 0;
				tick = 0;
				leg = 0;
				legLen = int'(repeatsRand) + 3;
			end
			gamePkg::Fly:
			begin
				mx += stepX(md);
				my += stepY(md);
				air++;
				if (tick == 3)	// Leg of four ticks ends
				begin
					leg++;
					if (leg == legLen)
					begin
						leg = 0;
						md = headingOf(int'(dirRand));
					end
				end
				tick = (tick + 1) % 4;
			end
			gamePkg::Bounce:
			begin
				if (mx <= 0 || mx >= `FIELD_X_MAX)
				begin
					md = mirrorSide(md, mx <= 0);
					mx = (mx <= 0) ? `BOUNCE_MARGIN : `FIELD_X_MAX - `BOUNCE_MARGIN;
				end
				else if (my <= `FIELD_Y_MIN || my >= `FIELD_Y_START)
				begin
					md = mirrorFloor(md, my <= `FIELD_Y_MIN);
					my = (my <= `FIELD_Y_MIN) ? `FIELD_Y_MIN + `BOUNCE_MARGIN :
						`FIELD_Y_START - `BOUNCE_MARGIN;
				end
			end
			gamePkg::DuckFall: my += `FALL_STEP;
			default: ;
		endcase

		hold = (ns != ms) ? 0 : ((hold < 63) ? hold + 1 : hold);
		ms = ns;
	endtask

	// Outputs and inputs are both settled at the falling edge
	always @(negedge ANIM_Clk)
	begin
		if (Reset)
			resetModel();
		compareAll();
		if (!Reset)
			advanceModel();
	end

endmodule

// File: tests/tb_duckHunt.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module tb_duckHunt;

	logic ANIM_Clk;
	logic Reset;
	logic run;
	logic startGame;
	logic duckKill;
	logic [1:0] shotCount;
	logic [1:0] colorRand;
	logic [2:0] dirRand;
	logic [1:0] repeatsRand;
	logic [9:0] startXRand;
	gamePkg::gameState state;
	gamePkg::coord_t duckX;
	gamePkg::coord_t duckY;
	gamePkg::duckDir duckDir;
	logic [1:0] duckColor;
	logic flyAway;
	logic shootEnable;
	logic outOfShots;
	logic gameOver;
	logic [3:0] duckNumber;
	logic [9:0] killMask;
	logic [3:0] killTotal;
	logic [7:0] roundNumber;
	int errors;
	int checks;
	logic [4:0] seen;

	logic [15:0] lfsr;
	logic [9:0] bits;
	int roundIdx;	// Rounds finished so far
	int duck;
	int flyTicks;
	int action;
	int missed;

	duckHuntTop i_duckHuntTop (.*);
	duckHuntChecker i_checker (.*);

	// 16 bit Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [9:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	// 0 flies off, 1 is shot, 2 empties the gun
	function automatic int duckPlan(input int r, input int d);
		case (r)
			0: return (d == 3 || d == 9) ? 0 : ((d == 6) ? 2 : 1);
			1: return (d % 3 == 2) ? 1 : ((d == 4) ? 2 : 0);
			default: return (d == 7) ? 2 : 1;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////
	// Player script, applied just after each rising edge
	//////////////////////////////////////////////////////////////
	task automatic driveTick();
		drawBits(2, bits);
		colorRand = bits[1:0];
		drawBits(3, bits);
		dirRand = bits[2:0];
		drawBits(2, bits);
		repeatsRand = bits[1:0];
		drawBits(10, bits);
		startXRand = bits;
		run = 1'b1;
		startGame = (state == gamePkg::MainMenu);
		case (state)
			gamePkg::DuckStart:
			begin
				duck++;
				flyTicks = 0;
				action = duckPlan(roundIdx, duck);
				duckKill = 1'b0;
				shotCount = 2'd0;
			end
			gamePkg::Fly:
			begin
				flyTicks++;
				duckKill = (action == 1 && flyTicks > 3 + duck);	// Later ducks fly longer
				if (action == 2 && flyTicks > 5)
					shotCount = 2'd3;
			end
			gamePkg::EndRound:
			begin
				roundIdx++;
				duck = 0;
			end
			default: duckKill = 1'b0;
		endcase
	endtask

	initial
	begin
		ANIM_Clk = 1'b0;
		forever
			#2 ANIM_Clk = ~ANIM_Clk;
	end

	// Three rounds of ten ducks, 120 ticks each at most
	initial
	begin
		#(3 * `DUCKS_PER_ROUND * 120 * 4);
		$display("timeout: the game did not get through three rounds in time");
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		Reset = 1'b1;
		run = 1'b0;
		startGame = 1'b0;
		duckKill = 1'b0;
		shotCount = 2'd0;
		colorRand = 2'd0;
		dirRand = 3'd0;
		repeatsRand = 2'd0;
		startXRand = 10'd0;
		lfsr = 16'd12;
		roundIdx = 0;
		duck = 0;
		flyTicks = 0;
		action = 0;
		missed = 0;
		repeat (3) @(posedge ANIM_Clk);
		#0.5;
		Reset = 1'b0;
		while (!(roundIdx == 3 && (state == gamePkg::Intro || state == gamePkg::MainMenu)))
		begin
			@(posedge ANIM_Clk);
			#0.5;
			driveTick();
		end
		repeat (2) @(posedge ANIM_Clk);
		if (seen != 5'b11111)
		begin
			$display("not every scenario was exercised: bounce, kill, fly-off, laugh, game over = %b",
				seen);
			missed = 1;
		end
		$display("checks %0d, errors %0d", checks, errors + missed);
		if (errors + missed == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/duckFlight.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module duckFlight (
	input logic ANIM_Clk,
	input logic Reset,
	input logic [1:0] colorRand,
	input logic [2:0] dirRand,
	input logic [1:0] repeatsRand,
	input logic [9:0] startXRand,
	flightIf.flight fl,
	output logic [1:0] color,
	output logic flyAway
);

	logic [5:0] airTimer;
	logic [1:0] tickCnt;	// Ticks within a leg
	logic [2:0] legCnt;
	logic [2:0] legLen;
	gamePkg::coord_t stepX;
	gamePkg::coord_t stepY;
	logic hitLeft;
	logic hitRight;
	logic hitTop;
	logic hitBottom;

	// Codes 6 and 7 have no direction of their own
	function automatic gamePkg::duckDir mapDir(input logic [2:0] r);
		if (r > 3'd5)
			return gamePkg::SE;
		return gamePkg::duckDir'(r);
	endfunction

	assign hitLeft = (fl.x <= 0);
	assign hitRight = (fl.x >= `FIELD_X_MAX);
	assign hitTop = (fl.y <= `FIELD_Y_MIN);
	assign hitBottom = (fl.y >= `FIELD_Y_START);

	assign fl.atEdge = hitLeft | hitRight | hitTop | hitBottom;
	assign fl.landed = (fl.y > `FALL_Y_END);
	assign fl.timeUp = (airTimer >= `FLYAWAY_LIMIT);
	assign flyAway = (airTimer >= `FLYAWAY_WARN) && (airTimer < `FLYAWAY_LIMIT);

	//////////////////////////////////////////////////////////////
	// Step table
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		stepX = '0;
		stepY = '0;
		case (fl.dir)
			gamePkg::NW:
			begin
				stepX = -gamePkg::coord_t'(`STEP_SM_X);
				stepY = -gamePkg::coord_t'(`STEP_LG_Y);
			end
			gamePkg::W:
			begin
				stepX = -gamePkg::coord_t'(`STEP_LG_X);
				stepY = -gamePkg::coord_t'(`STEP_SM_Y);
			end
			gamePkg::NE:
			begin
				stepX = gamePkg::coord_t'(`STEP_SM_X);
				stepY = -gamePkg::coord_t'(`STEP_LG_Y);
			end
			gamePkg::E:
			begin
				stepX = gamePkg::coord_t'(`STEP_LG_X);
				stepY = -gamePkg::coord_t'(`STEP_SM_Y);
			end
			gamePkg::SW:
			begin
				stepX = -gamePkg::coord_t'(`STEP_SM_X);
				stepY = gamePkg::coord_t'(`STEP_LG_Y);
			end
			gamePkg::SE:
			begin
				stepX = gamePkg::coord_t'(`STEP_SM_X);
				stepY = gamePkg::coord_t'(`STEP_LG_Y);
			end
			default: ;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			fl.x <= 11'sd400;
			fl.y <= 11'sd300;
			fl.dir <= gamePkg::NW;
			color <= 2'd0;
			airTimer <= '0;
			tickCnt <= '0;
			legCnt <= '0;
			legLen <= 3'd3;
		end
		else
		begin
			case (fl.cmd)
				gamePkg::CmdSpawn:
				begin
					fl.x <= gamePkg::coord_t'({1'b0, startXRand});
					fl.y <= gamePkg::coord_t'(`FIELD_Y_START);
					fl.dir <= mapDir(dirRand);
					color <= (colorRand == 2'd3) ? 2'd0 : colorRand;
					airTimer <= '0;
					tickCnt <= '0;
					legCnt <= '0;
					legLen <= {1'b0, repeatsRand} + 3'd3;
				end
				gamePkg::CmdFly:
				begin
					fl.x <= fl.x + stepX;
					fl.y <= fl.y + stepY;
					airTimer <= airTimer + 6'd1;
					tickCnt <= tickCnt + 2'd1;
					if (tickCnt == 2'd3)	// End of a leg
					begin
						if (legCnt == legLen - 3'd1)
						begin
							legCnt <= '0;
							fl.dir <= mapDir(dirRand);
						end
						else
							legCnt <= legCnt + 3'd1;
					end
				end
				gamePkg::CmdBounce:
				begin
					// Side walls win in a corner
					if (hitLeft)
					begin
						fl.x <= gamePkg::coord_t'(`BOUNCE_MARGIN);
						case (fl.dir)
							gamePkg::NW: fl.dir <= gamePkg::NE;
							gamePkg::W: fl.dir <= gamePkg::E;
							gamePkg::SW: fl.dir <= gamePkg::SE;
							default: ;
						endcase
					end
					else if (hitRight)
					begin
						fl.x <= gamePkg::coord_t'(`FIELD_X_MAX - `BOUNCE_MARGIN);
						case (fl.dir)
							gamePkg::NE: fl.dir <= gamePkg::NW;
							gamePkg::E: fl.dir <= gamePkg::W;
							gamePkg::SE: fl.dir <= gamePkg::SW;
							default: ;
						endcase
					end
					else if (hitTop)
					begin
						fl.y <= gamePkg::coord_t'(`FIELD_Y_MIN + `BOUNCE_MARGIN);
						case (fl.dir)
							gamePkg::NW, gamePkg::W: fl.dir <= gamePkg::SW;
							gamePkg::NE, gamePkg::E: fl.dir <= gamePkg::SE;
							default: ;
						endcase
					end
					else if (hitBottom)
					begin
						fl.y <= gamePkg::coord_t'(`FIELD_Y_START - `BOUNCE_MARGIN);
						case (fl.dir)
							gamePkg::SW: fl.dir <= gamePkg::NW;
							gamePkg::SE: fl.dir <= gamePkg::NE;
							default: ;
						endcase
					end
				end
				gamePkg::CmdFall: fl.y <= fl.y + gamePkg::coord_t'(`FALL_STEP);
				default: ;
			endcase
		end
	end

	// A step taken from inside the field overshoots by one step at most
	overshoot: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		(fl.cmd == gamePkg::CmdFly && !fl.atEdge) |=>
		(fl.x >= -`STEP_LG_X && fl.x <= `FIELD_X_MAX + `STEP_LG_X &&
		fl.y >= `FIELD_Y_MIN - `STEP_LG_Y && fl.y <= `FIELD_Y_START + `STEP_LG_Y))
		else $error("duck left the field by more than one step");

endmodule

// File: verilog/duckHuntTop.sv
`timescale 1ns/1ps

module duckHuntTop (
	input logic ANIM_Clk,
	input logic Reset,
	input logic run,
	input logic startGame,
	input logic duckKill,
	input logic [1:0] shotCount,
	input logic [1:0] colorRand,
	input logic [2:0] dirRand,
	input logic [1:0] repeatsRand,
	input logic [9:0] startXRand,
	output gamePkg::gameState state,
	output gamePkg::coord_t duckX,
	output gamePkg::coord_t duckY,
	output gamePkg::duckDir duckDir,
	output logic [1:0] duckColor,
	output logic flyAway,
	output logic shootEnable,
	output logic outOfShots,
	output logic gameOver,
	output logic [3:0] duckNumber,
	output logic [9:0] killMask,
	output logic [3:0] killTotal,
	output logic [7:0] roundNumber
);

	flightIf fl();
	scoreIf sc();

	gameSequencer i_gameSequencer (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.startGame(startGame),
		.duckKill(duckKill),
		.shotCount(shotCount),
		.fl(fl.seq),
		.sc(sc.seq),
		.state(state),
		.shootEnable(shootEnable),
		.outOfShots(outOfShots)
	);

	duckFlight i_duckFlight (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.colorRand(colorRand),
		.dirRand(dirRand),
		.repeatsRand(repeatsRand),
		.startXRand(startXRand),
		.fl(fl.flight),
		.color(duckColor),
		.flyAway(flyAway)
	);

	roundScore i_roundScore (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.sc(sc.score),
		.duckNumber(duckNumber),
		.killMask(killMask),
		.killTotal(killTotal),
		.roundNumber(roundNumber)
	);

	assign duckX = fl.x;
	assign duckY = fl.y;
	assign duckDir = fl.dir;
	assign gameOver = sc.gameOver;

endmodule

// File: verilog/gameIfs.sv
`timescale 1ns/1ps

// Sequencer <-> duck motion
interface flightIf;
	gamePkg::flightCmd cmd;
	logic atEdge;
	logic landed;
	logic timeUp;
	gamePkg::coord_t x;
	gamePkg::coord_t y;
	gamePkg::duckDir dir;

	modport seq (output cmd, input atEdge, input landed, input timeUp);
	modport flight (input cmd, output atEdge, output landed, output timeUp,
		output x, output y, output dir);
endinterface

// Sequencer <-> round bookkeeping
interface scoreIf;
	logic newDuck;		// One-tick strobes
	logic duckHit;
	logic newRound;
	logic clearGame;
	logic roundDone;	// Levels
	logic gameOver;

	modport seq (output newDuck, output duckHit, output newRound, output clearGame,
		input roundDone, input gameOver);
	modport score (input newDuck, input duckHit, input newRound, input clearGame,
		output roundDone, output gameOver);
endinterface

// File: verilog/gamePkg.sv
package gamePkg;

	// Game flow
	typedef enum logic [3:0]
	{
		Idle,
		MainMenu,
		Intro,
		DuckStart,
		Fly,
		Bounce,
		DuckHit,
		DuckFall,
		DogShow,
		FlyOff,
		DogLaugh,
		EndRound,
		GameOver,
		NewRound
	} gameState;

	// Encoding matches the random direction input
	typedef enum logic [2:0] {NW, W, NE, E, SW, SE} duckDir;

	// Sequencer to flight module
	typedef enum logic [2:0] {CmdHold, CmdSpawn, CmdFly, CmdBounce, CmdFall} flightCmd;

	typedef logic signed [10:0] coord_t;	// Screen coordinate

endpackage

// File: verilog/gameSequencer.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module gameSequencer (
	input logic ANIM_Clk,
	input logic Reset,
	input logic run,
	input logic startGame,
	input logic duckKill,
	input logic [1:0] shotCount,
	flightIf.seq fl,
	scoreIf.seq sc,
	output gamePkg::gameState state,
	output logic shootEnable,
	output logic outOfShots
);

	gamePkg::gameState nextState;
	logic [5:0] holdCnt;	// Ticks spent in current state
	logic [5:0] holdLen;
	logic holdDone;
	logic firstTick;

	always_comb
	begin
		case (state)
			gamePkg::Intro: holdLen = 6'(`INTRO_TICKS);
			gamePkg::DuckHit: holdLen = 6'(`SHOCK_TICKS);
			gamePkg::DogShow: holdLen = 6'(`DOG_TICKS);
			gamePkg::FlyOff: holdLen = 6'(`FLYOFF_TICKS);
			gamePkg::DogLaugh: holdLen = 6'(`LAUGH_TICKS);
			gamePkg::GameOver: holdLen = 6'(`GAMEOVER_TICKS);
			gamePkg::NewRound: holdLen = 6'(`NEWROUND_TICKS);
			default: holdLen = 6'd1;
		endcase
	end

	assign holdDone = (holdCnt == holdLen - 6'd1);
	assign firstTick = (holdCnt == 6'd0);

	//////////////////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		case (state)
			gamePkg::Idle: if (run) nextState = gamePkg::MainMenu;
			gamePkg::MainMenu: if (startGame) nextState = gamePkg::Intro;
			gamePkg::Intro: if (holdDone) nextState = gamePkg::DuckStart;
			gamePkg::DuckStart: nextState = gamePkg::Fly;
			gamePkg::Fly:
			begin
				if (outOfShots)
					nextState = gamePkg::DogLaugh;
				else if (fl.timeUp)
					nextState = gamePkg::FlyOff;
				else if (duckKill)
					nextState = gamePkg::DuckHit;
				else if (fl.atEdge)
					nextState = gamePkg::Bounce;
			end
			gamePkg::Bounce: nextState = gamePkg::Fly;
			gamePkg::DuckHit: if (holdDone) nextState = gamePkg::DuckFall;
			gamePkg::DuckFall: if (fl.landed) nextState = gamePkg::DogShow;
			gamePkg::DogShow, gamePkg::DogLaugh:
				if (holdDone)
					nextState = sc.roundDone ? gamePkg::EndRound : gamePkg::DuckStart;
			gamePkg::FlyOff: if (holdDone) nextState = gamePkg::DogLaugh;
			gamePkg::EndRound:
				nextState = sc.gameOver ? gamePkg::GameOver : gamePkg::NewRound;
			gamePkg::GameOver: if (holdDone) nextState = gamePkg::MainMenu;
			gamePkg::NewRound: if (holdDone) nextState = gamePkg::Intro;
			default: nextState = gamePkg::Idle;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= gamePkg::Idle;
			holdCnt <= '0;
			outOfShots <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (nextState != state)
				holdCnt <= '0;
			else if (holdCnt != 6'h3f)
				holdCnt <= holdCnt + 6'd1;	// Saturate in open-ended states

			if (state == gamePkg::DuckStart)
				outOfShots <= 1'b0;
			else if (state == gamePkg::Fly && shotCount == 2'd3)
				outOfShots <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////
	// Commands and strobes
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		case (state)
			gamePkg::DuckStart: fl.cmd = gamePkg::CmdSpawn;
			gamePkg::Fly: fl.cmd = gamePkg::CmdFly;
			gamePkg::Bounce: fl.cmd = gamePkg::CmdBounce;
			gamePkg::DuckFall: fl.cmd = gamePkg::CmdFall;
			default: fl.cmd = gamePkg::CmdHold;
		endcase
	end

	assign sc.newDuck = (state == gamePkg::DuckStart);
	assign sc.duckHit = (state == gamePkg::DuckHit) && firstTick;
	assign sc.newRound = (state == gamePkg::NewRound) && firstTick;
	assign sc.clearGame = (state == gamePkg::MainMenu) && firstTick;
	assign shootEnable = (state == gamePkg::Fly);

	stateLegal: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		state <= gamePkg::NewRound)
		else $error("state register left the enum range");

endmodule

// File: verilog/game_cfg.svh
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

//////////////////////////////////////////////////////////////
// Playfield geometry
//////////////////////////////////////////////////////////////
`define FIELD_X_MAX 576		// Right wall
`define FIELD_Y_MIN 0		// Sky line
`define FIELD_Y_START 236	// Grass line, spawn height
`define FALL_Y_END 300		// Duck lands below this
`define BOUNCE_MARGIN 20	// Placement after a reflection

//////////////////////////////////////////////////////////////
// Motion per animation tick
//////////////////////////////////////////////////////////////
`define STEP_LG_X 15
`define STEP_SM_X 12
`define STEP_LG_Y 10
`define STEP_SM_Y 2
`define FALL_STEP 10

// Air time, in ticks
`define FLYAWAY_LIMIT 60
`define FLYAWAY_WARN 50

//////////////////////////////////////////////////////////////
// Hold lengths and round size
//////////////////////////////////////////////////////////////
`define DUCKS_PER_ROUND 10
`define INTRO_TICKS 40
`define SHOCK_TICKS 16
`define DOG_TICKS 18
`define LAUGH_TICKS 12
`define FLYOFF_TICKS 4
`define GAMEOVER_TICKS 11
`define NEWROUND_TICKS 6

// Minimum kills to survive a round
`define THRESH_R10 6
`define THRESH_R12 7
`define THRESH_R14 8
`define THRESH_R19 9
`define THRESH_HIGH 10

`endif

// File: verilog/roundScore.sv
`timescale 1ns/1ps
`include "game_cfg.svh"

module roundScore (
	input logic ANIM_Clk,
	input logic Reset,
	scoreIf.score sc,
	output logic [3:0] duckNumber,
	output logic [9:0] killMask,
	output logic [3:0] killTotal,
	output logic [7:0] roundNumber
);

	logic [3:0] thresh;

	// Later rounds ask for more kills
	always_comb
	begin
		if (roundNumber <= 8'd10)
			thresh = 4'(`THRESH_R10);
		else if (roundNumber <= 8'd12)
			thresh = 4'(`THRESH_R12);
		else if (roundNumber <= 8'd14)
			thresh = 4'(`THRESH_R14);
		else if (roundNumber <= 8'd19)
			thresh = 4'(`THRESH_R19);
		else
			thresh = 4'(`THRESH_HIGH);
	end

	assign sc.roundDone = (duckNumber >= 4'(`DUCKS_PER_ROUND));

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			duckNumber <= '0;
			killMask <= '0;
			killTotal <= '0;
			roundNumber <= 8'd1;
			sc.gameOver <= 1'b0;
		end
		else if (sc.clearGame)	// Back at the menu
		begin
			duckNumber <= '0;
			killMask <= '0;
			killTotal <= '0;
			roundNumber <= 8'd1;
			sc.gameOver <= 1'b0;
		end
		else
		begin
			if (sc.newRound)
			begin
				roundNumber <= roundNumber + 8'd1;
				duckNumber <= '0;
				killMask <= '0;
				killTotal <= '0;
			end
			else
			begin
				if (sc.newDuck)
					duckNumber <= duckNumber + 4'd1;
				if (sc.duckHit && duckNumber != 4'd0)
				begin
					killMask[duckNumber - 4'd1] <= 1'b1;
					killTotal <= killTotal + 4'd1;
				end
			end
			if (sc.roundDone)
				sc.gameOver <= (killTotal < thresh);
		end
	end

	killBound: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		killTotal <= duckNumber)
		else $error("more kills than ducks in the round");

endmodule
